// File: Makefile
# Verilator build and run for the program page engine

VERILATOR ?= verilator
TOP ?= programPageTb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -j $(JOBS)

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the log decides, the simulator status alone is not enough
run: compile
	./$(BINARY) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "TB PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
logic/nandProgramPkg.sv
logic/caFrameBuilder.sv
logic/programPageSequencer.sv
logic/programPageTop.sv
sim/primitiveEngineModel.sv
sim/programPageTb.sv

// File: logic/caFrameBuilder.sv
`timescale 1ns/10ps

module caFrameBuilder
    import nandProgramPkg::*;
(
    input  logic              iSystemClock,
    input  logic              iReset,
    input  logic              accept,
    input  programRequest_t   cmdRequest,
    input  programStep_t      step,
    output primitiveRequest_t primRequest
);

    programOption_t          latchedOption;
    logic [lengthWidth-1:0]  latchedLength;
    logic [numberOfWays-1:0] latchedWays;
    logic [colWidth-1:0]     latchedCol;
    logic [rowWidth-1:0]     latchedRow;
    logic [7:0]              confirmByte;
    logic [caDataWidth-1:0]  addressBytes;

    // request is taken in the accept cycle itself
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            latchedOption <= optNormal;
            latchedLength <= '0;
            latchedWays <= '0;
            latchedCol <= '0;
            latchedRow <= '0;
        end else if (accept) begin
            latchedOption <= programOption_t'(cmdRequest.option[1:0]);
            latchedLength <= cmdRequest.length;
            latchedWays <= cmdRequest.waySelect;
            latchedCol <= cmdRequest.colAddress;
            latchedRow <= cmdRequest.rowAddress;
        end
    end

    // option 3 is not defined and sends the normal confirm
    always_comb begin
        case (latchedOption)
            optCache: begin
                confirmByte = cmdCacheConfirm;
            end
            optMultiplane: begin
                confirmByte = cmdMultiplaneConfirm;
            end
            default: begin
                confirmByte = cmdProgramConfirm;
            end
        endcase
    end

    // column low byte goes out first, row high byte last
    assign addressBytes = {latchedCol[7:0], latchedCol[15:8],
                           latchedRow[7:0], latchedRow[15:8], latchedRow[23:16]};

    always_comb begin
        primRequest.command = primNone;
        primRequest.targetWay = '0;
        primRequest.numOfData = '0;
        primRequest.caSelect = 1'b1;
        primRequest.caData = '0;
        case (step)
            stepSetupCmd: begin
                primRequest.command = primCaSend;
                primRequest.targetWay = latchedWays;
                primRequest.caData = {cmdProgramSetup, {(caDataWidth-8){1'b0}}};
            end
            stepAddress: begin
                primRequest.command = primCaSend;
                primRequest.targetWay = latchedWays;
                primRequest.numOfData = addressByteCountMinusOne;
                primRequest.caSelect = 1'b0;
                primRequest.caData = addressBytes;
            end
            stepData: begin
                primRequest.command = primDataOut;
                primRequest.targetWay = latchedWays;
                primRequest.numOfData = latchedLength;
                primRequest.caSelect = 1'b0;
            end
            stepConfirmCmd: begin
                primRequest.command = primCaSend;
                primRequest.targetWay = latchedWays;
                primRequest.caData = {confirmByte, {(caDataWidth-8){1'b0}}};
            end
            default: begin
                // idle, nothing requested
                primRequest.command = primNone;
            end
        endcase
    end

    commandOneHot: assert property (
        @(posedge iSystemClock) disable iff (iReset)
        $onehot0(primRequest.command)
    ) else $error("primitive command is not one-hot");

endmodule

// File: logic/nandProgramPkg.sv
package nandProgramPkg;

    // way-select mask width
    localparam int numberOfWays = 4;

    // host command port
    localparam int opcodeWidth = 6;
    localparam logic [opcodeWidth-1:0] programPageOpcode = 6'b000011;
    localparam int optionWidth = 5;
    localparam int lengthWidth = 16;

    // NAND address fields
    localparam int colWidth = 16;
    localparam int rowWidth = 24;

    // five command/address bytes on the primitive side
    localparam int caDataWidth = 40;

    // primitive last-step and command vector width
    localparam int primitiveCount = 8;

    // bit positions in the primitive vectors
    localparam int caSendBit = 3;
    localparam int dataOutBit = 2;

    // NAND command bytes for program page
    localparam logic [7:0] cmdProgramSetup = 8'h80;
    localparam logic [7:0] cmdProgramConfirm = 8'h10;
    localparam logic [7:0] cmdCacheConfirm = 8'h15;
    localparam logic [7:0] cmdMultiplaneConfirm = 8'h11;

    // five address bytes, so the primitive engine gets 4
    localparam logic [lengthWidth-1:0] addressByteCountMinusOne = 16'd4;

    typedef enum logic [2:0] {
        stepIdle       = 3'd0,
        stepSetupCmd   = 3'd1,
        stepAddress    = 3'd2,
        stepData       = 3'd3,
        stepConfirmCmd = 3'd4
    } programStep_t;

    // one-hot request to the primitive engine
    typedef enum logic [primitiveCount-1:0] {
        primNone    = 8'h00,
        primDataOut = 8'h04,
        primCaSend  = 8'h08
    } primitiveSel_t;

    // low bits of the option field, value 3 falls back to normal
    typedef enum logic [1:0] {
        optNormal     = 2'd0,
        optCache      = 2'd1,
        optMultiplane = 2'd2
    } programOption_t;

    typedef struct packed {
        logic [opcodeWidth-1:0]  opcode;
        logic [optionWidth-1:0]  option;
        logic [lengthWidth-1:0]  length;
        logic [numberOfWays-1:0] waySelect;
        logic [colWidth-1:0]     colAddress;
        logic [rowWidth-1:0]     rowAddress;
    } programRequest_t;

    typedef struct packed {
        primitiveSel_t           command;
        logic [numberOfWays-1:0] targetWay;
        logic [lengthWidth-1:0]  numOfData;
        // 1 for a command byte, 0 for address bytes
        logic                    caSelect;
        logic [caDataWidth-1:0]  caData;
    } primitiveRequest_t;

endpackage

// File: logic/programPageSequencer.sv
`timescale 1ns/10ps

module programPageSequencer
    import nandProgramPkg::*;
(
    input  logic                      iSystemClock,
    input  logic                      iReset,
    input  logic                      cmdValid,
    input  logic [opcodeWidth-1:0]    opcode,
    input  logic [primitiveCount-1:0] primLastStep,
    output logic                      cmdReady,
    output logic                      start,
    output logic                      accept,
    output logic                      lastStep,
    output programStep_t              step
);

    programStep_t nextStep;
    logic         opcodeMatch;
    logic         acceptCmd;
    logic         stepDone;
    logic         confirmDone;

    // only program page is taken, other opcodes wait on the port
    assign opcodeMatch = (opcode == programPageOpcode);

    // cmdReady is low for the whole sequence, so no idle check here
    assign acceptCmd = cmdValid && cmdReady && opcodeMatch;

    assign start = acceptCmd;
    assign accept = acceptCmd;

    // each step ends on the last-step bit of its own primitive
    always_comb begin
        case (step)
            stepSetupCmd: begin
                stepDone = primLastStep[caSendBit];
            end
            stepAddress: begin
                stepDone = primLastStep[caSendBit];
            end
            stepData: begin
                stepDone = primLastStep[dataOutBit];
            end
            stepConfirmCmd: begin
                stepDone = primLastStep[caSendBit];
            end
            default: begin
                stepDone = 1'b0;
            end
        endcase
    end

    assign confirmDone = (step == stepConfirmCmd) && stepDone;

    always_comb begin
        case (step)
            stepIdle: begin
                nextStep = acceptCmd ? stepSetupCmd : stepIdle;
            end
            stepSetupCmd: begin
                nextStep = stepDone ? stepAddress : stepSetupCmd;
            end
            stepAddress: begin
                nextStep = stepDone ? stepData : stepAddress;
            end
            stepData: begin
                nextStep = stepDone ? stepConfirmCmd : stepData;
            end
            stepConfirmCmd: begin
                nextStep = stepDone ? stepIdle : stepConfirmCmd;
            end
            default: begin
                nextStep = stepIdle;
            end
        endcase
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            step <= stepIdle;
        end else begin
            step <= nextStep;
        end
    end

    // host handshake, ready drops after accept and returns with lastStep
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            cmdReady <= 1'b1;
            lastStep <= 1'b0;
        end else begin
            lastStep <= confirmDone;
            if (acceptCmd) begin
                cmdReady <= 1'b0;
            end else if (confirmDone) begin
                cmdReady <= 1'b1;
            end
        end
    end

    // completion pulse only right after the confirm byte went out
    lastStepAfterConfirm: assert property (
        @(posedge iSystemClock) disable iff (iReset)
        lastStep |-> ($past(step) == stepConfirmCmd) && (step == stepIdle) && cmdReady
    ) else $error("lastStep outside the cycle after the confirm step");

    acceptOnlyWhenIdle: assert property (
        @(posedge iSystemClock) disable iff (iReset)
        accept |-> (step == stepIdle)
    ) else $error("command accepted while a sequence is running");

endmodule

// File: logic/programPageTop.sv
`timescale 1ns/10ps

module programPageTop
    import nandProgramPkg::*;
(
    input  logic                      iSystemClock,
    input  logic                      iReset,

    // host command port
    input  programRequest_t           cmdRequest,
    input  logic                      cmdValid,
    output logic                      cmdReady,
    output logic                      start,
    output logic                      lastStep,

    // primitive engine side
    output primitiveRequest_t         primRequest,
    input  logic [primitiveCount-1:0] primLastStep
);

    logic         accept;
    programStep_t step;

    // opcode filter, handshake and step order
    programPageSequencer sequencer_i (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .cmdValid     (cmdValid),
        .opcode       (cmdRequest.opcode),
        .primLastStep (primLastStep),
        .cmdReady     (cmdReady),
        .start        (start),
        .accept       (accept),
        .lastStep     (lastStep),
        .step         (step)
    );

    // request latch and per-step primitive request
    caFrameBuilder frameBuilder_i (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .accept       (accept),
        .cmdRequest   (cmdRequest),
        .step         (step),
        .primRequest  (primRequest)
    );

endmodule

// File: sim/primitiveEngineModel.sv
`timescale 1ns/10ps

module primitiveEngineModel
    import nandProgramPkg::*;
(
    input  logic                      iSystemClock,
    input  logic                      iReset,
    input  primitiveRequest_t         primRequest,
    output logic [primitiveCount-1:0] primLastStep,
    output logic                      stepSeen,
    output primitiveRequest_t         seenRequest,
    output logic                      holdError
);

    logic [31:0] lcgState;
    logic        busy;
    int          delayCount;

    // 1 to 6 cycles, taken from the upper LCG bits
    function automatic int randomDelay();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return 1 + int'(lcgState[31:16] % 16'd6);
    endfunction

    // looks at the request 2 ns after each rising edge and answers from there
    initial begin
        lcgState = 32'h6994_2087;
        primLastStep = '0;
        stepSeen = 1'b0;
        seenRequest = '0;
        holdError = 1'b0;
        busy = 1'b0;
        delayCount = 0;
        forever begin
            @(posedge iSystemClock);
            #2;
            primLastStep = '0;
            stepSeen = 1'b0;
            if (iReset) begin
                busy = 1'b0;
            end else if (busy) begin
                // request must stay put until this step is answered
                if (primRequest != seenRequest) begin
                    holdError = 1'b1;
                end
                delayCount--;
                if (delayCount == 0) begin
                    // command is one-hot, so it is also the matching last-step bit
                    primLastStep = seenRequest.command;
                    busy = 1'b0;
                end
            end else if (primRequest.command != primNone) begin
                seenRequest = primRequest;
                stepSeen = 1'b1;
                busy = 1'b1;
                delayCount = randomDelay();
            end
        end
    end

endmodule

// File: sim/programPageTb.sv
`timescale 1ns/10ps

module programPageTb
    import nandProgramPkg::*;
();

    logic                      iSystemClock;
    logic                      iReset;
    programRequest_t           cmdRequest;
    logic                      cmdValid;
    logic                      cmdReady;
    logic                      start;
    logic                      lastStep;
    primitiveRequest_t         primRequest;
    logic [primitiveCount-1:0] primLastStep;
    logic                      stepSeen;
    primitiveRequest_t         seenRequest;
    logic                      holdError;

    primitiveRequest_t seenSteps[$];
    logic [31:0]       lcgState;
    int                errorCount;
    int                checkCount;
    int                testCount;
    int                startCount;
    int                lastStepCount;
    int                issuedCount;
    logic              inFlight;
    logic              timedOut;

    programPageTop dut_i (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .cmdRequest   (cmdRequest),
        .cmdValid     (cmdValid),
        .cmdReady     (cmdReady),
        .start        (start),
        .lastStep     (lastStep),
        .primRequest  (primRequest),
        .primLastStep (primLastStep)
    );

    primitiveEngineModel primModel_i (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .primRequest  (primRequest),
        .primLastStep (primLastStep),
        .stepSeen     (stepSeen),
        .seenRequest  (seenRequest),
        .holdError    (holdError)
    );

    initial begin
        iSystemClock = 1'b0;
        forever begin
            #20 iSystemClock = ~iSystemClock;
        end
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[FAIL] %0d ns: %s, got %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic driveAfterEdge();
        @(posedge iSystemClock);
        #2;
    endtask

    // waits on falling edges for start or lastStep, optionally with start held off
    task automatic waitForPulse(input bit waitLast, input bit startHeldOff);
        int   cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < 200) begin
            @(negedge iSystemClock);
            seen = waitLast ? lastStep : start;
            if (!seen && startHeldOff) begin
                checkValue(64'(start), 64'd0, "second request accepted before lastStep");
            end
            cycles++;
        end
        if (!seen) begin
            timedOut = 1'b1;
            $display("timeout at %0d ns: %s did not arrive within 200 cycles", $time,
                     waitLast ? "lastStep" : "start");
        end
    endtask

    function automatic programRequest_t randomRequest();
        programRequest_t req;
        logic [31:0]     r0;
        logic [31:0]     r1;
        logic [31:0]     r2;
        r0 = nextRandom();
        r1 = nextRandom();
        r2 = nextRandom();
        req.opcode = programPageOpcode;
        req.option = r0[31:27];
        req.waySelect = r0[26:23];
        req.length = r1[31:16];
        req.colAddress = r2[31:16];
        req.rowAddress = {r1[15:8], r2[15:0]};
        return req;
    endfunction

    // expected primitive request for step 0 to 3 of a program page
    function automatic primitiveRequest_t expectedStep(input programRequest_t req, input int index);
        primitiveRequest_t exp;
        logic [7:0]        confirm;
        exp.command = primCaSend;
        exp.targetWay = req.waySelect;
        exp.numOfData = '0;
        exp.caSelect = 1'b1;
        exp.caData = '0;
        case (req.option[1:0])
            2'd1: confirm = 8'h15;
            2'd2: confirm = 8'h11;
            default: confirm = 8'h10;
        endcase
        case (index)
            0: exp.caData = {8'h80, 32'h0};
            1: begin
                exp.numOfData = 16'd4;
                exp.caSelect = 1'b0;
                exp.caData = {req.colAddress[7:0], req.colAddress[15:8], req.rowAddress[7:0],
                              req.rowAddress[15:8], req.rowAddress[23:16]};
            end
            2: begin
                exp.command = primDataOut;
                exp.numOfData = req.length;
                exp.caSelect = 1'b0;
            end
            default: exp.caData = {confirm, 32'h0};
        endcase
        return exp;
    endfunction

    task automatic checkSequence(input programRequest_t req);
        primitiveRequest_t seen;
        primitiveRequest_t exp;
        int                i;
        checkValue(64'(seenSteps.size()), 64'd4, "number of primitive steps");
        for (i = 0; i < 4 && seenSteps.size() > 0; i++) begin
            seen = seenSteps.pop_front();
            exp = expectedStep(req, i);
            checkValue(64'(seen.command), 64'(exp.command), $sformatf("step %0d command", i));
            checkValue(64'(seen.targetWay), 64'(exp.targetWay), $sformatf("step %0d way", i));
            checkValue(64'(seen.numOfData), 64'(exp.numOfData), $sformatf("step %0d count", i));
            checkValue(64'(seen.caSelect), 64'(exp.caSelect), $sformatf("step %0d caSelect", i));
            checkValue(64'(seen.caData), 64'(exp.caData), $sformatf("step %0d caData", i));
        end
        seenSteps.delete();
    endtask

    task automatic runCommand(input programRequest_t req);
        int startsBefore;
        int lastsBefore;
        startsBefore = startCount;
        lastsBefore = lastStepCount;
        driveAfterEdge();
        cmdRequest = req;
        cmdValid = 1'b1;
        waitForPulse(1'b0, 1'b0);
        driveAfterEdge();
        cmdValid = 1'b0;
        if (!timedOut) begin
            waitForPulse(1'b1, 1'b0);
        end
        if (timedOut) begin
            return;
        end
        driveAfterEdge();
        issuedCount++;
        checkValue(64'(startCount - startsBefore), 64'd1, "start pulses for one command");
        checkValue(64'(lastStepCount - lastsBefore), 64'd1, "lastStep pulses for one command");
        checkSequence(req);
    endtask

    // second request stays valid while the first one runs
    task automatic runOverlapped(input programRequest_t first, input programRequest_t second);
        logic accepted;
        driveAfterEdge();
        cmdRequest = first;
        cmdValid = 1'b1;
        waitForPulse(1'b0, 1'b0);
        driveAfterEdge();
        cmdRequest = second;
        if (!timedOut) begin
            waitForPulse(1'b1, 1'b1);
        end
        accepted = start;
        if (!timedOut) begin
            checkValue(64'(accepted), 64'd1, "second request accepted with lastStep");
        end
        driveAfterEdge();
        cmdValid = 1'b0;
        if (timedOut) begin
            return;
        end
        issuedCount++;
        checkSequence(first);
        if (accepted !== 1'b1) begin
            return;
        end
        waitForPulse(1'b1, 1'b0);
        if (timedOut) begin
            return;
        end
        driveAfterEdge();
        issuedCount++;
        checkSequence(second);
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        testCount++;
        $display("test %0d %s: %0d errors%s", testCount, name, errorCount - errorsBefore,
                 timedOut ? ", timed out" : "");
    endtask

    // pulse counting, step collection and the cmdReady rule while busy
    always @(negedge iSystemClock) begin
        if (!iReset) begin
            if (stepSeen) begin
                seenSteps.push_back(seenRequest);
            end
            if (inFlight && !lastStep) begin
                checkValue(64'(cmdReady), 64'd0, "cmdReady high during a running command");
            end
            if (start) begin
                startCount++;
            end
            if (lastStep) begin
                lastStepCount++;
                checkValue(64'(cmdReady), 64'd1, "cmdReady with lastStep");
                inFlight = 1'b0;
            end
            if (start) begin
                inFlight = 1'b1;
            end
        end
    end

    initial begin
        programRequest_t req;
        logic [31:0]     r;
        int              errorsBefore;
        int              i;
        lcgState = 32'h6994_2087;
        iReset = 1'b1;
        cmdValid = 1'b0;
        cmdRequest = '0;
        errorCount = 0;
        checkCount = 0;
        testCount = 0;
        startCount = 0;
        lastStepCount = 0;
        issuedCount = 0;
        inFlight = 1'b0;
        timedOut = 1'b0;
        repeat (8) @(posedge iSystemClock);
        #2;
        iReset = 1'b0;

        errorsBefore = errorCount;
        @(negedge iSystemClock);
        checkValue(64'(cmdReady), 64'd1, "cmdReady after reset");
        checkValue(64'(start), 64'd0, "start after reset");
        checkValue(64'(lastStep), 64'd0, "lastStep after reset");
        checkValue(64'(primRequest.command), 64'(primNone), "primitive command after reset");
        checkValue(64'(primRequest.caSelect), 64'd1, "caSelect after reset");
        checkValue(64'(primRequest.numOfData), 64'd0, "numOfData after reset");
        checkValue(64'(primRequest.caData), 64'd0, "caData after reset");
        reportTest("reset values", errorsBefore);

        errorsBefore = errorCount;
        for (i = 0; i < 40 && !timedOut; i++) begin
            runCommand(randomRequest());
        end
        reportTest("random program pages", errorsBefore);

        // every low option value, 3 included
        errorsBefore = errorCount;
        for (i = 0; i < 4 && !timedOut; i++) begin
            req = randomRequest();
            req.option[1:0] = i[1:0];
            runCommand(req);
        end
        reportTest("confirm byte per option", errorsBefore);

        errorsBefore = errorCount;
        if (!timedOut) begin
            req = randomRequest();
            r = nextRandom();
            req.opcode = r[31:26];
            if (req.opcode == programPageOpcode) begin
                req.opcode = ~programPageOpcode;
            end
            driveAfterEdge();
            cmdRequest = req;
            cmdValid = 1'b1;
            repeat (10) begin
                @(negedge iSystemClock);
                checkValue(64'(start), 64'd0, "start for a foreign opcode");
                checkValue(64'(cmdReady), 64'd1, "cmdReady for a foreign opcode");
                checkValue(64'(primRequest.command), 64'(primNone), "command for a foreign opcode");
                checkValue(64'(primRequest.targetWay), 64'd0, "way for a foreign opcode");
            end
            driveAfterEdge();
            cmdValid = 1'b0;
            checkValue(64'(seenSteps.size()), 64'd0, "steps seen for a foreign opcode");
        end
        reportTest("foreign opcode ignored", errorsBefore);

        errorsBefore = errorCount;
        for (i = 0; i < 3 && !timedOut; i++) begin
            runOverlapped(randomRequest(), randomRequest());
        end
        reportTest("request held during a command", errorsBefore);

        errorsBefore = errorCount;
        checkValue(64'(startCount), 64'(issuedCount), "total start pulses");
        checkValue(64'(lastStepCount), 64'(issuedCount), "total lastStep pulses");
        checkValue(64'(holdError), 64'd0, "primitive request stable within each step");
        reportTest("pulse totals and step hold", errorsBefore);

        $display("tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
        if (errorCount == 0 && !timedOut) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
